/* design/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // fetch ports with one cache each
    localparam int NUM_PORTS = 4;
    localparam int PORT_W = $clog2(NUM_PORTS);

    // tag above index above byte offset
    localparam int ADDR_W = 16;
    localparam int OFFSET_W = 2;
    localparam int INDEX_W = 4;
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_LINES = 1 << INDEX_W;

    localparam int DATA_W = 32;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        FLUSH
    } cache_state_t;

endpackage

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // words in the instruction memory
    localparam int MEM_DEPTH = 1024;
    localparam int MEM_AW = $clog2(MEM_DEPTH);

    // cycles from first mem_valid cycle to mem_ack
    localparam int MEM_LATENCY = 3;
    localparam int LAT_W = $clog2(MEM_LATENCY + 1);

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_t;

endpackage

`default_nettype wire

/* design/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    input  logic              fetch_valid,
    input  logic [ADDR_W-1:0] fetch_addr,
    output logic              fetch_ready,
    output logic [DATA_W-1:0] fetch_data,
    input  logic              flush,

    output logic              miss_valid,
    output logic [ADDR_W-1:0] miss_addr,
    input  logic              miss_ack,
    input  logic [DATA_W-1:0] miss_data
);

    cache_state_t state;

    logic [ADDR_W-1:0]  req_addr;
    logic [INDEX_W-1:0] req_index;
    logic [TAG_W-1:0]   req_tag;
    logic               hit;

    logic [TAG_W-1:0]     tag_arr [NUM_LINES];
    logic [DATA_W-1:0]    data_arr [NUM_LINES];
    logic [NUM_LINES-1:0] valid;

    logic [INDEX_W-1:0] flush_idx;

    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_tag = req_addr[ADDR_W-1 -: TAG_W];

    assign hit = valid[req_index] && (tag_arr[req_index] == req_tag);

    // data only counts while fetch_ready is high
    assign fetch_ready = (state == LOOKUP) && hit;
    assign fetch_data = data_arr[req_index];

    // one word per line so the refill address is just word aligned
    assign miss_valid = (state == REFILL);
    assign miss_addr = {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= IDLE;
            valid <= '0;
            flush_idx <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (flush)
                    begin
                        state <= FLUSH;
                        flush_idx <= '0;
                    end
                    else if (fetch_valid)
                    begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP:
                begin
                    if (hit)
                    begin
                        state <= IDLE;
                    end
                    else
                    begin
                        state <= REFILL;
                    end
                end
                REFILL:
                begin
                    // line is written here and hits on the next cycle
                    if (miss_ack)
                    begin
                        state <= LOOKUP;
                        valid[req_index] <= 1'b1;
                    end
                end
                FLUSH:
                begin
                    valid[flush_idx] <= 1'b0;
                    flush_idx <= flush_idx + 1'b1;
                    if (flush_idx == INDEX_W'(NUM_LINES - 1))
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request address latched when the fetch is taken
    always_ff @(posedge clk)
    begin
        if (state == IDLE && fetch_valid)
        begin
            req_addr <= fetch_addr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == REFILL && miss_ack)
        begin
            tag_arr[req_index] <= req_tag;
            data_arr[req_index] <= miss_data;
        end
    end

endmodule

`default_nettype wire

/* design/fetch_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_arbiter
    import icache_pkg::*;
    import mem_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,

    input  logic [NUM_PORTS-1:0]               miss_valid,
    input  logic [NUM_PORTS-1:0][ADDR_W-1:0]   miss_addr,
    output logic [NUM_PORTS-1:0]               miss_ack,
    output logic [DATA_W-1:0]                  miss_data,

    input  logic                               load_valid,
    input  logic [ADDR_W-1:0]                  load_addr,
    input  logic [DATA_W-1:0]                  load_data,
    output logic                               load_ack,

    output logic                               mem_valid,
    output mem_op_t                            mem_op,
    output logic [ADDR_W-1:0]                  mem_addr,
    output logic [DATA_W-1:0]                  mem_wdata,
    input  logic                               mem_ack,
    input  logic [DATA_W-1:0]                  mem_rdata
);

    logic              busy;
    logic              grant_load;
    logic [PORT_W-1:0] grant_idx;
    logic [PORT_W-1:0] rr_ptr;

    logic              pick_found;
    logic [PORT_W-1:0] pick_idx;

    // first requesting cache at or after rr_ptr
    always_comb
    begin
        int unsigned cand;
        pick_found = 1'b0;
        pick_idx = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            cand = (int'(rr_ptr) + i) % NUM_PORTS;
            if (!pick_found && miss_valid[cand])
            begin
                pick_found = 1'b1;
                pick_idx = PORT_W'(cand);
            end
        end
    end

    assign mem_valid = busy;

    // return path back to the owner of the grant
    assign load_ack = mem_ack && grant_load;
    assign miss_data = mem_rdata;

    always_comb
    begin
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            miss_ack[p] = mem_ack && !grant_load && (grant_idx == PORT_W'(p));
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            grant_load <= 1'b0;
            rr_ptr <= '0;
        end
        else if (!busy)
        begin
            // boot loads go ahead of misses
            if (load_valid || pick_found)
            begin
                busy <= 1'b1;
                grant_load <= load_valid;
            end
        end
        else if (mem_ack)
        begin
            busy <= 1'b0;
            if (!grant_load)
            begin
                rr_ptr <= (grant_idx == PORT_W'(NUM_PORTS - 1)) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!busy)
        begin
            grant_idx <= pick_idx;
            mem_wdata <= load_data;
            if (load_valid)
            begin
                mem_op <= MEM_WRITE;
                mem_addr <= load_addr;
            end
            else
            begin
                mem_op <= MEM_READ;
                mem_addr <= miss_addr[pick_idx];
            end
        end
    end

endmodule

`default_nettype wire

/* design/inst_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_mem
    import icache_pkg::*;
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_valid,
    input  mem_op_t           mem_op,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_wdata,
    output logic              mem_ack,
    output logic [DATA_W-1:0] mem_rdata
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    logic              active;
    logic [LAT_W-1:0]  cnt;
    logic              last;
    logic [MEM_AW-1:0] word_addr;

    assign word_addr = mem_addr[OFFSET_W +: MEM_AW];

    // access happens on the edge that raises mem_ack
    assign last = active && !mem_ack && (cnt == LAT_W'(MEM_LATENCY - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active <= 1'b0;
            cnt <= '0;
            mem_ack <= 1'b0;
        end
        else
        begin
            mem_ack <= 1'b0;
            if (!active)
            begin
                if (mem_valid)
                begin
                    active <= 1'b1;
                    cnt <= LAT_W'(1);
                end
            end
            else if (mem_ack)
            begin
                // arbiter drops mem_valid on this same edge
                active <= 1'b0;
            end
            else if (last)
            begin
                mem_ack <= 1'b1;
            end
            else
            begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (last)
        begin
            if (mem_op == MEM_WRITE)
            begin
                mem[word_addr] <= mem_wdata;
            end
            mem_rdata <= mem[word_addr];
        end
    end

endmodule

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import icache_pkg::*;
    import mem_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,

    input  logic [NUM_PORTS-1:0]             fetch_valid,
    input  logic [NUM_PORTS-1:0][ADDR_W-1:0] fetch_addr,
    output logic [NUM_PORTS-1:0]             fetch_ready,
    output logic [NUM_PORTS-1:0][DATA_W-1:0] fetch_data,
    input  logic [NUM_PORTS-1:0]             flush,

    input  logic                             load_valid,
    input  logic [ADDR_W-1:0]                load_addr,
    input  logic [DATA_W-1:0]                load_data,
    output logic                             load_ack
);

    logic [NUM_PORTS-1:0]             miss_valid;
    logic [NUM_PORTS-1:0][ADDR_W-1:0] miss_addr;
    logic [NUM_PORTS-1:0]             miss_ack;
    logic [DATA_W-1:0]                miss_data;

    logic              mem_valid;
    mem_op_t           mem_op;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic              mem_ack;
    logic [DATA_W-1:0] mem_rdata;

    // one cache per fetch port sharing miss_data
    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_cache
        icache u_icache (
            .clk         (clk),
            .rst         (rst),
            .fetch_valid (fetch_valid[p]),
            .fetch_addr  (fetch_addr[p]),
            .fetch_ready (fetch_ready[p]),
            .fetch_data  (fetch_data[p]),
            .flush       (flush[p]),
            .miss_valid  (miss_valid[p]),
            .miss_addr   (miss_addr[p]),
            .miss_ack    (miss_ack[p]),
            .miss_data   (miss_data)
        );
    end

    fetch_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .miss_valid (miss_valid),
        .miss_addr  (miss_addr),
        .miss_ack   (miss_ack),
        .miss_data  (miss_data),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .load_ack   (load_ack),
        .mem_valid  (mem_valid),
        .mem_op     (mem_op),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    inst_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

/* dv/tb_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch
    import icache_pkg::*;
    import mem_pkg::*;
();

    localparam int MISS_BOUND = (NUM_PORTS + 1) * (MEM_LATENCY + 2) + 3;
    localparam int N_LOADS = 8;
    localparam int LIST_W = $clog2(N_LOADS);
    localparam int N_ROUNDS = 6;
    localparam int N_OPS = 3 * N_LOADS + N_ROUNDS + 8;
    localparam int TIMEOUT = N_OPS * MISS_BOUND + NUM_LINES + 100;

    logic                             clk;
    logic                             rst;
    logic [NUM_PORTS-1:0]             fetch_valid;
    logic [NUM_PORTS-1:0][ADDR_W-1:0] fetch_addr;
    logic [NUM_PORTS-1:0]             fetch_ready;
    logic [NUM_PORTS-1:0][DATA_W-1:0] fetch_data;
    logic [NUM_PORTS-1:0]             flush;
    logic                             load_valid;
    logic [ADDR_W-1:0]                load_addr;
    logic [DATA_W-1:0]                load_data;
    logic                             load_ack;

    logic [31:0]       lfsr;
    logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
    logic [ADDR_W-1:0] load_list [N_LOADS];
    logic [ADDR_W-1:0] req_a [NUM_PORTS];
    logic [DATA_W-1:0] exp_d [NUM_PORTS];
    int                lat [NUM_PORTS];
    int                errors;
    int                checks;
    int                cycles;

    fetch_top UUT (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .flush       (flush),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .load_ack    (load_ack)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT)
        begin
            $display("run stopped: no finish within %0d cycles", TIMEOUT);
            $display("checks %0d, errors %0d", checks, errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [MEM_AW-1:0] word_of(input logic [ADDR_W-1:0] a);
        word_of = a[OFFSET_W +: MEM_AW];
    endfunction

    function automatic logic [ADDR_W-1:0] byte_addr(input logic [MEM_AW-1:0] w);
        byte_addr = {{(ADDR_W - MEM_AW - OFFSET_W){1'b0}}, w, {OFFSET_W{1'b0}}};
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("[ERROR] %s got 0x%h expected 0x%h", what, got, exp);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic load_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        load_valid = 1'b1;
        load_addr = addr;
        load_data = data;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!load_ack && waited < MISS_BOUND);
        load_valid = 1'b0;
        checks++;
        assert (load_ack)
        else
            report_failure($sformatf("load to 0x%h not acknowledged in %0d cycles",
                                     addr, MISS_BOUND));
        if (load_ack)
        begin
            ref_mem[word_of(addr)] = data;
        end
    endtask

    // fetches req_a on every port in mask at once and compares with exp_d
    task automatic run_fetch(input logic [NUM_PORTS-1:0] mask);
        logic [NUM_PORTS-1:0] pending;
        int waited;
        pending = mask;
        waited = 0;
        @(negedge clk);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (mask[p])
            begin
                fetch_valid[p] = 1'b1;
                fetch_addr[p] = req_a[p];
                lat[p] = 0;
            end
        end
        while (pending != '0 && waited < MISS_BOUND)
        begin
            @(negedge clk);
            waited++;
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (pending[p] && fetch_ready[p])
                begin
                    checks++;
                    assert (fetch_data[p] == exp_d[p])
                    else
                        report_mismatch($sformatf("fetch_data[%0d]", p), fetch_data[p], exp_d[p]);
                    fetch_valid[p] = 1'b0;
                    pending[p] = 1'b0;
                    lat[p] = waited;
                end
                else if (!mask[p])
                begin
                    assert (!fetch_ready[p])
                    else
                        report_failure($sformatf("fetch_ready on idle port %0d", p));
                end
            end
        end
        checks++;
        assert (pending == '0)
        else
            report_failure($sformatf("ports %b not served within %0d cycles",
                                     pending, MISS_BOUND));
        fetch_valid = '0;
    endtask

    initial
    begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr_x;
        logic [DATA_W-1:0] old_word;
        logic [DATA_W-1:0] new_word;
        int                port;
        clk = 1'b0;
        rst = 1'b1;
        fetch_valid = '0;
        fetch_addr = '0;
        flush = '0;
        load_valid = 1'b0;
        load_addr = '0;
        load_data = '0;
        lfsr = 32'h49d7;
        errors = 0;
        checks = 0;
        cycles = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // quiet after reset
        repeat (8)
        begin
            @(negedge clk);
            checks++;
            assert (fetch_ready == '0 && !load_ack)
            else
                report_failure("fetch_ready or load_ack seen with no request");
        end

        // first two share an index with different tags
        take_bits(MEM_AW, r);
        load_list[0] = byte_addr(r[MEM_AW-1:0]);
        load_list[1] = load_list[0] ^ ADDR_W'(1 << (OFFSET_W + INDEX_W));
        for (int i = 2; i < N_LOADS; i++)
        begin
            take_bits(MEM_AW, r);
            load_list[i] = byte_addr(r[MEM_AW-1:0]);
        end
        for (int i = 0; i < N_LOADS; i++)
        begin
            take_bits(DATA_W, r);
            load_word(load_list[i], r);
        end

        // cold miss then the same address again as a hit
        for (int i = 0; i < N_LOADS; i++)
        begin
            take_bits(PORT_W, r);
            port = int'(r[PORT_W-1:0]);
            req_a[port] = load_list[i];
            exp_d[port] = ref_mem[word_of(load_list[i])];
            run_fetch(NUM_PORTS'(1) << port);
            run_fetch(NUM_PORTS'(1) << port);
            checks++;
            assert (lat[port] == 1)
            else
                report_mismatch($sformatf("hit latency port %0d", port), 32'(lat[port]), 32'd1);
        end

        for (int round = 0; round < N_ROUNDS; round++)
        begin
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                take_bits(LIST_W, r);
                req_a[p] = load_list[r[LIST_W-1:0]];
            end
            if (round == 0)
            begin
                req_a[0] = load_list[0];
                req_a[1] = load_list[1];
            end
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                exp_d[p] = ref_mem[word_of(req_a[p])];
            end
            run_fetch('1);
        end

        // reload and flush port 0 only while port 1 keeps the stale word
        addr_x = load_list[2];
        old_word = ref_mem[word_of(addr_x)];
        req_a[0] = addr_x;
        req_a[1] = addr_x;
        exp_d[0] = old_word;
        exp_d[1] = old_word;
        run_fetch(NUM_PORTS'(3));
        take_bits(DATA_W, r);
        new_word = old_word ^ (r | 32'h1);
        load_word(addr_x, new_word);
        @(negedge clk);
        flush[0] = 1'b1;
        @(negedge clk);
        flush[0] = 1'b0;
        repeat (NUM_LINES + 2) @(negedge clk);
        exp_d[0] = new_word;
        run_fetch(NUM_PORTS'(1));
        exp_d[1] = old_word;
        run_fetch(NUM_PORTS'(2));
        checks++;
        assert (lat[1] == 1)
        else
            report_mismatch("hit latency port 1", 32'(lat[1]), 32'd1);

        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
design/icache_pkg.sv
design/mem_pkg.sv
design/icache.sv
design/fetch_arbiter.sv
design/inst_mem.sv
design/fetch_top.sv
dv/tb_fetch.sv

/* Makefile */
SIM        ?= verilator
TOP        ?= tb_fetch
FILELIST   ?= compile.f
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status follows the pass line in the simulator output
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
